// ==== Makefile ====
# Verilator build for the video transmit testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= VideoTxTb
FILELIST  ?= VideoTxTop.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
JOBS      ?= 4

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== VideoTxTop.f ====
src/VideoTxPkg.sv
src/VideoSyncGen.sv
src/LayerCsr.sv
src/SquareLayer.sv
src/LayerMixer.sv
src/VideoTxTop.sv
tests/VideoTxTb.sv

// ==== src/LayerCsr.sv ====
/*
 * Write-only register file, one write per clock when iCsrWe is high
 * A write lands at the clock edge and is visible from the next cycle
 * Unmapped addresses and the fourth word of each layer block are ignored
 */
`timescale 1ns/1ps
`default_nettype none

module LayerCsr
(
	input  wire                                    iVCLK,
	input  wire                                    iVRST,
	input  wire                                    iCsrWe,
	input  wire  [VideoTxPkg::lpCsrAdrsWidth-1:0]  iCsrAdrs,
	input  wire  VideoTxPkg::CsrWordU              iCsrWd,
	output logic                                   oEnable,
	output logic [VideoTxPkg::lpColorWidth-1:0]    oBackColor,
	output VideoTxPkg::LayerCfgT                   oLayerCfg [VideoTxPkg::lpLayerNum]
);
	import VideoTxPkg::*;

	// Address relative to the first layer block
	logic [lpCsrAdrsWidth-1:0]   wLayerAdrs;
	// Layer index and word offset
	logic [lpCsrAdrsWidth-3:0]   wIdx;
	logic [1:0]                  wOfs;
	logic                        wLayerSel;
	// Colour view of the write data
	logic [lpColorWidth-1:0]     wColor;

	logic                        rEnable;
	logic [lpColorWidth-1:0]     rBackColor;
	LayerCfgT [lpLayerNum-1:0]   rLayerCfg;

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------
	assign wLayerAdrs = iCsrAdrs - lpCsrAdrsWidth'(lpAdrsLayerBase);
	assign wIdx       = wLayerAdrs[lpCsrAdrsWidth-1:2];
	assign wOfs       = wLayerAdrs[1:0];
	assign wLayerSel  = (iCsrAdrs >= lpAdrsLayerBase);
	assign wColor     = {iCsrWd.color.red, iCsrWd.color.green, iCsrWd.color.blue};

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			rEnable    <= 1'b0;
			rBackColor <= '0;
			rLayerCfg  <= '0;
		end
		else if (iCsrWe)
		begin
			if (iCsrAdrs == lpAdrsCtrl)
				rEnable <= iCsrWd[0];
			else if (iCsrAdrs == lpAdrsBack)
				rBackColor <= wColor;
			else if (wLayerSel && (wIdx < lpLayerNum))
			begin
				case (wOfs)
					lpOfsColor: rLayerCfg[wIdx].color <= wColor;
					// Edge view, high word is right or under
					lpOfsHEdge:
					begin
						rLayerCfg[wIdx].left  <= iCsrWd.edges.low;
						rLayerCfg[wIdx].right <= iCsrWd.edges.high;
					end
					lpOfsVEdge:
					begin
						rLayerCfg[wIdx].top   <= iCsrWd.edges.low;
						rLayerCfg[wIdx].under <= iCsrWd.edges.high;
					end
					default: ;
				endcase
			end
		end
	end

	assign oEnable    = rEnable;
	assign oBackColor = rBackColor;

	always_comb
	begin
		for (int i = 0; i < lpLayerNum; i++)
			oLayerCfg[i] = rLayerCfg[i];
	end

	// Layer writes past the last unit leave every layer untouched
	assert property (@(posedge iVCLK) disable iff (iVRST)
		iCsrWe && wLayerSel && (wIdx >= lpLayerNum) |=> $stable(rLayerCfg))
		else $error("LayerCsr: out-of-range layer write changed a layer");

endmodule

`default_nettype wire

// ==== src/LayerMixer.sv ====
/*
 * Lowest layer index wins, background colour where no layer hits
 * iHit must trail iRaster by exactly one clock
 * Pixel and flags leave two clocks after iRaster, pixel is zero outside de
 */
`timescale 1ns/1ps
`default_nettype none

module LayerMixer
(
	input  wire                                   iVCLK,
	input  wire                                   iVRST,
	input  wire  VideoTxPkg::LayerHitT            iHit [VideoTxPkg::lpLayerNum],
	input  wire  VideoTxPkg::RasterT              iRaster,
	input  wire  [VideoTxPkg::lpColorWidth-1:0]   iBackColor,
	output logic [VideoTxPkg::lpColorWidth-1:0]   oVideoDq,
	output logic                                  oVideoHs,
	output logic                                  oVideoVs,
	output logic                                  oVideoDe,
	output logic                                  oVideoFe
);
	import VideoTxPkg::*;

	// Flag delay line, bit order de hs vs fe
	logic [3:0]              rFlag1;
	logic [3:0]              rFlag2;
	// Winning colour
	logic [lpColorWidth-1:0] wPick;
	logic [lpColorWidth-1:0] rDq;

	// --------------------------------------------------
	// Priority select
	// --------------------------------------------------
	always_comb
	begin
		wPick = iBackColor;
		// Walk downward, so the lowest hitting index is assigned last
		for (int i = lpLayerNum - 1; i >= 0; i--)
		begin
			if (iHit[i].hit)
				wPick = iHit[i].color;
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			rFlag1 <= '0;
			rFlag2 <= '0;
		end
		else
		begin
			rFlag1 <= {iRaster.de, iRaster.hs, iRaster.vs, iRaster.fe};
			rFlag2 <= rFlag1;
		end
		// rFlag1 lines up with the hits
		rDq <= rFlag1[3] ? wPick : '0;
	end

	assign oVideoDq = rDq;
	assign oVideoDe = rFlag2[3];
	assign oVideoHs = rFlag2[2];
	assign oVideoVs = rFlag2[1];
	assign oVideoFe = rFlag2[0];

	// Blanking holds for pixel and enable together
	assert property (@(posedge iVCLK) disable iff (iVRST)
		!oVideoDe |-> (oVideoDq == '0))
		else $error("LayerMixer: pixel %h outside de", oVideoDq);

endmodule

`default_nettype wire

// ==== src/SquareLayer.sv ====
/*
 * One rectangle layer with half-open bounds [left,right) x [top,under)
 * An empty or inverted rectangle never hits
 * Output follows iRaster by one clock and does not look at de
 */
`timescale 1ns/1ps
`default_nettype none

module SquareLayer
(
	input  wire  VideoTxPkg::RasterT   iRaster,
	input  wire  VideoTxPkg::LayerCfgT iCfg,
	input  wire                        iVCLK,
	input  wire                        iVRST,
	output VideoTxPkg::LayerHitT       oHit
);
	import VideoTxPkg::*;

	// Edge tests
	logic     wInH;
	logic     wInV;
	LayerHitT rHit;

	assign wInH = (iCfg.left <= iRaster.hPos) && (iRaster.hPos < iCfg.right);
	assign wInV = (iCfg.top <= iRaster.vPos) && (iRaster.vPos < iCfg.under);

	// New pixel every clock, so several are in flight here and in the mixer
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			rHit.hit <= 1'b0;
		else
			rHit.hit <= wInH && wInV;
		// Colour rides along with its hit flag
		rHit.color <= iCfg.color;
	end

	assign oHit = rHit;

endmodule

`default_nettype wire

// ==== src/VideoSyncGen.sv ====
/*
 * Free-running raster walk, no back-pressure
 * Counters sit at (0,0) while iEnable is low and start in its first high cycle
 * oRaster is a registered copy of the counter position and its decoded flags,
 * so every position reaches oRaster one clock after the counters hold it
 */
`timescale 1ns/1ps
`default_nettype none

module VideoSyncGen
(
	input  wire                iVCLK,
	input  wire                iVRST,
	input  wire                iEnable,
	output VideoTxPkg::RasterT oRaster
);
	import VideoTxPkg::*;

	// Pixel and line counters
	logic [lpPosWidth-1:0] rHCnt;
	logic [lpPosWidth-1:0] rVCnt;
	// Wrap points
	logic                  wHLast;
	logic                  wVLast;
	// Position and flags before the output register
	RasterT                wRasterNext;
	RasterT                rRaster;

	// --------------------------------------------------
	// Counters
	// --------------------------------------------------
	assign wHLast = (rHCnt == lpHTotal - 1);
	assign wVLast = (rVCnt == lpVTotal - 1);

	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !iEnable)
		begin
			rHCnt <= '0;
			rVCnt <= '0;
		end
		else if (wHLast)
		begin
			// End of line, step the line counter
			rHCnt <= '0;
			rVCnt <= wVLast ? '0 : rVCnt + 1'b1;
		end
		else
			rHCnt <= rHCnt + 1'b1;
	end

	// --------------------------------------------------
	// Region decode
	// --------------------------------------------------
	always_comb
	begin
		wRasterNext.hPos = rHCnt;
		wRasterNext.vPos = rVCnt;
		// Active area only where both counters are active
		wRasterNext.de   = (rHCnt < lpHActive) && (rVCnt < lpVActive);
		wRasterNext.hs   = (rHCnt >= lpHSyncStart) && (rHCnt < lpHSyncStart + lpHSync);
		// Whole lines of vertical sync
		wRasterNext.vs   = (rVCnt >= lpVSyncStart) && (rVCnt < lpVSyncStart + lpVSync);
		// Single clock at the very end of the frame
		wRasterNext.fe   = wHLast && wVLast;
	end

	// Flags forced low while stopped
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			rRaster <= '0;
		else if (!iEnable)
			rRaster <= '0;
		else
			rRaster <= wRasterNext;
	end

	assign oRaster = rRaster;

	// Counters never leave the raster
	assert property (@(posedge iVCLK) disable iff (iVRST)
		(rHCnt < lpHTotal) && (rVCnt < lpVTotal))
		else $error("VideoSyncGen: counter outside raster (%0d,%0d)", rHCnt, rVCnt);

endmodule

`default_nettype wire

// ==== src/VideoTxPkg.sv ====
/*
 * Shared raster timing, CSR register map and bus types of the video path
 * Raster sizes are fixed at elaboration and cannot be changed by software
 * All CSR registers are write-only, with no read-back path
 */
`default_nettype none

package VideoTxPkg;

	// --------------------------------------------------
	// Raster timing
	// --------------------------------------------------
	// Horizontal lengths in clocks
	localparam int lpHActive = 16;
	localparam int lpHFront  = 2;
	localparam int lpHSync   = 2;
	localparam int lpHBack   = 2;
	// Vertical lengths in lines
	localparam int lpVActive = 8;
	localparam int lpVFront  = 1;
	localparam int lpVSync   = 1;
	localparam int lpVBack   = 1;

	// Line and frame totals
	localparam int lpHTotal = lpHActive + lpHFront + lpHSync + lpHBack;
	localparam int lpVTotal = lpVActive + lpVFront + lpVSync + lpVBack;
	// First count of each sync window
	localparam int lpHSyncStart = lpHActive + lpHFront;
	localparam int lpVSyncStart = lpVActive + lpVFront;

	// --------------------------------------------------
	// Widths and layer count
	// --------------------------------------------------
	localparam int lpPosWidth     = 16;
	localparam int lpColorWidth   = 24;
	localparam int lpLayerNum     = 7;
	localparam int lpCsrAdrsWidth = 6;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	// Bit 0 runs the raster
	localparam int lpAdrsCtrl = 0;
	localparam int lpAdrsBack = 1;
	// Layer n sits at base + 4n, four words per layer
	localparam int lpAdrsLayerBase = 4;
	// Word offsets inside one layer block
	localparam int lpOfsColor = 0;
	localparam int lpOfsHEdge = 1;
	localparam int lpOfsVEdge = 2;

	// --------------------------------------------------
	// Types
	// --------------------------------------------------
	// CSR word seen as an RGB colour
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} CsrColorT;

	// CSR word seen as a pair of rectangle edges
	typedef struct packed {
		logic [15:0] high;
		logic [15:0] low;
	} CsrEdgeT;

	// Decoding depends on the target address
	typedef union packed {
		CsrColorT color;
		CsrEdgeT  edges;
	} CsrWordU;

	typedef struct packed {
		logic [lpPosWidth-1:0] hPos;
		logic [lpPosWidth-1:0] vPos;
		logic                  de;
		logic                  hs;
		logic                  vs;
		logic                  fe;
	} RasterT;

	typedef struct packed {
		logic [lpColorWidth-1:0] color;
		logic [lpPosWidth-1:0]   left;
		logic [lpPosWidth-1:0]   right;
		logic [lpPosWidth-1:0]   top;
		logic [lpPosWidth-1:0]   under;
	} LayerCfgT;

	typedef struct packed {
		logic                    hit;
		logic [lpColorWidth-1:0] color;
	} LayerHitT;

endpackage

`default_nettype wire

// ==== src/VideoTxTop.sv ====
/*
 * Single clock video transmit path, everything on iVCLK
 * Outputs for a raster position appear two clocks after oRaster showed it
 * All video outputs stay low until software sets the enable bit
 */
`timescale 1ns/1ps
`default_nettype none

module VideoTxTop
(
	input  wire                                  iVCLK,
	input  wire                                  iVRST,
	input  wire                                  iCsrWe,
	input  wire [VideoTxPkg::lpCsrAdrsWidth-1:0] iCsrAdrs,
	input  wire VideoTxPkg::CsrWordU             iCsrWd,
	output wire [VideoTxPkg::lpColorWidth-1:0]   oVideoDq,
	output wire                                  oVideoHs,
	output wire                                  oVideoVs,
	output wire                                  oVideoDe,
	output wire                                  oVideoFe
);
	import VideoTxPkg::*;

	wire                          wEnable;
	wire [lpColorWidth-1:0]       wBackColor;
	wire LayerCfgT                wLayerCfg [lpLayerNum];
	wire RasterT                  wRaster;
	wire LayerHitT                wHit [lpLayerNum];

	// --------------------------------------------------
	// Settings and raster
	// --------------------------------------------------
	LayerCsr LayerCsr (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.iCsrWe(iCsrWe),        .iCsrAdrs(iCsrAdrs),      .iCsrWd(iCsrWd),
		.oEnable(wEnable),      .oBackColor(wBackColor),  .oLayerCfg(wLayerCfg)
	);

	VideoSyncGen VideoSyncGen (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.iEnable(wEnable),      .oRaster(wRaster)
	);

	// --------------------------------------------------
	// Layer array, index 0 has top priority
	// --------------------------------------------------
	for (genvar gi = 0; gi < lpLayerNum; gi++)
	begin : genLayer
		SquareLayer SquareLayer (
			.iRaster(wRaster),  .iCfg(wLayerCfg[gi]),
			.iVCLK(iVCLK),      .iVRST(iVRST),
			.oHit(wHit[gi])
		);
	end

	LayerMixer LayerMixer (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.iHit(wHit),            .iRaster(wRaster),        .iBackColor(wBackColor),
		.oVideoDq(oVideoDq),
		.oVideoHs(oVideoHs),    .oVideoVs(oVideoVs),
		.oVideoDe(oVideoDe),    .oVideoFe(oVideoFe)
	);

endmodule

`default_nettype wire

// ==== tests/VideoTxTb.sv ====
/*
 * Random layer scenes from a fixed LFSR seed, checked every clock
 * Model raster starts with the enable write, outputs trail it by two clocks
 * Rewrites happen only in vertical blanking, so no visible pixel moves
 */
`timescale 1ns/1ps
`default_nettype none

module VideoTxTb;
	import VideoTxPkg::*;

	// --------------------------------------------------
	// Run length
	// --------------------------------------------------
	localparam int lpTestNum   = 6;
	localparam int lpFrameNum  = 3;
	localparam int lpCfgCycles = 160;
	// Doubled for margin, plus reset
	localparam int lpWatchdogNs =
		2 * 4 * (lpTestNum * (lpFrameNum * lpHTotal * lpVTotal + lpCfgCycles) + 20);
	localparam logic [31:0] lpLfsrTaps = 32'h8020_0003;

	// Expected video outputs
	typedef struct packed {
		logic [lpColorWidth-1:0] dq;
		logic                    de;
		logic                    hs;
		logic                    vs;
		logic                    fe;
	} ExpOutT;

	logic                      iVCLK;
	logic                      iVRST;
	logic                      iCsrWe;
	logic [lpCsrAdrsWidth-1:0] iCsrAdrs;
	CsrWordU                   iCsrWd;
	logic [lpColorWidth-1:0]   oVideoDq;
	logic                      oVideoHs;
	logic                      oVideoVs;
	logic                      oVideoDe;
	logic                      oVideoFe;

	logic [31:0]             lfsrState = 32'h5882_6181;
	// Reference registers and counters
	LayerCfgT                mCfg [lpLayerNum];
	logic [lpColorWidth-1:0] mBack;
	logic                    mEn;
	int                      mH;
	int                      mV;
	RasterT                  mRaster;
	ExpOutT                  mStage2;
	ExpOutT                  mStage3;

	VideoTxTop dut (
		.iVCLK(iVCLK),        .iVRST(iVRST),
		.iCsrWe(iCsrWe),      .iCsrAdrs(iCsrAdrs),  .iCsrWd(iCsrWd),
		.oVideoDq(oVideoDq),  .oVideoHs(oVideoHs),  .oVideoVs(oVideoVs),
		.oVideoDe(oVideoDe),  .oVideoFe(oVideoFe)
	);

	initial iVCLK = 1'b0;
	always #2 iVCLK = ~iVCLK;

	// --------------------------------------------------
	// Random numbers
	// --------------------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lpLfsrTaps) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// Region flags straight from the raster rules
	function automatic RasterT rasterAt(input int h, input int v);
		RasterT r;
		r.hPos = 16'(h);
		r.vPos = 16'(v);
		r.de   = (h < lpHActive) && (v < lpVActive);
		r.hs   = (h >= lpHActive + lpHFront) && (h < lpHActive + lpHFront + lpHSync);
		r.vs   = (v >= lpVActive + lpVFront) && (v < lpVActive + lpVFront + lpVSync);
		r.fe   = (h == lpHTotal - 1) && (v == lpVTotal - 1);
		return r;
	endfunction

	// Lowest index wins, background otherwise, black outside de
	function automatic ExpOutT pixelFor(input RasterT r);
		ExpOutT o;
		logic   found;
		o     = '{dq: '0, de: r.de, hs: r.hs, vs: r.vs, fe: r.fe};
		found = 1'b0;
		for (int i = 0; i < lpLayerNum; i++)
		begin
			if (!found && (mCfg[i].left <= r.hPos) && (r.hPos < mCfg[i].right) &&
				(mCfg[i].top <= r.vPos) && (r.vPos < mCfg[i].under))
			begin
				o.dq  = mCfg[i].color;
				found = 1'b1;
			end
		end
		if (!found)
			o.dq = mBack;
		if (!r.de)
			o.dq = '0;
		return o;
	endfunction

	always @(posedge iVCLK)
	begin
		int idx;
		int ofs;
		idx = (int'(iCsrAdrs) - lpAdrsLayerBase) / 4;
		ofs = (int'(iCsrAdrs) - lpAdrsLayerBase) % 4;
		if (iVRST)
		begin
			for (int i = 0; i < lpLayerNum; i++)
				mCfg[i] <= '0;
			mBack   <= '0;
			mEn     <= 1'b0;
			mH      <= 0;
			mV      <= 0;
			mRaster <= '0;
			mStage2 <= '0;
			mStage3 <= '0;
		end
		else
		begin
			// Register writes, unmapped words fall through
			if (iCsrWe && (iCsrAdrs == lpAdrsCtrl))
				mEn <= iCsrWd[0];
			else if (iCsrWe && (iCsrAdrs == lpAdrsBack))
				mBack <= iCsrWd[23:0];
			else if (iCsrWe && (iCsrAdrs >= lpAdrsLayerBase) && (idx < lpLayerNum))
			begin
				if (ofs == 0)
					mCfg[idx].color <= iCsrWd[23:0];
				else if (ofs == 1)
				begin
					mCfg[idx].left  <= iCsrWd[15:0];
					mCfg[idx].right <= iCsrWd[31:16];
				end
				else if (ofs == 2)
				begin
					mCfg[idx].top   <= iCsrWd[15:0];
					mCfg[idx].under <= iCsrWd[31:16];
				end
			end
			// Raster walk, held at the origin while stopped
			if (!mEn)
			begin
				mH <= 0;
				mV <= 0;
			end
			else if (mH == lpHTotal - 1)
			begin
				mH <= 0;
				mV <= (mV == lpVTotal - 1) ? 0 : mV + 1;
			end
			else
				mH <= mH + 1;
			mRaster <= mEn ? rasterAt(mH, mV) : '0;
			// Two clocks from raster to pins
			mStage2 <= pixelFor(mRaster);
			mStage3 <= mStage2;
		end
	end

	// --------------------------------------------------
	// Checks on the falling edge
	// --------------------------------------------------
	task automatic valueError(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expVal, actVal);
		$display("Finished with errors");
		$fatal(1, "Output mismatch");
	endtask

	always @(negedge iVCLK)
	begin
		if (!iVRST)
		begin
			assert (oVideoDq === mStage3.dq)
				else valueError("oVideoDq", 32'(mStage3.dq), 32'(oVideoDq));
			assert (oVideoDe === mStage3.de)
				else valueError("oVideoDe", 32'(mStage3.de), 32'(oVideoDe));
			assert (oVideoHs === mStage3.hs)
				else valueError("oVideoHs", 32'(mStage3.hs), 32'(oVideoHs));
			assert (oVideoVs === mStage3.vs)
				else valueError("oVideoVs", 32'(mStage3.vs), 32'(oVideoVs));
			assert (oVideoFe === mStage3.fe)
				else valueError("oVideoFe", 32'(mStage3.fe), 32'(oVideoFe));
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic csrWrite(input int adrs, input logic [31:0] data);
		@(posedge iVCLK);
		iCsrWe   <= 1'b1;
		iCsrAdrs <= lpCsrAdrsWidth'(adrs);
		iCsrWd   <= data;
	endtask

	task automatic csrIdle();
		@(posedge iVCLK);
		iCsrWe <= 1'b0;
	endtask

	// Random edges 0..20 and 0..10, sometimes forced empty
	task automatic writeLayer(input int idx);
		logic [31:0] c;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] z;
		takeBits(32, c);
		csrWrite(lpAdrsLayerBase + 4 * idx + lpOfsColor, c);
		takeBits(5, a);
		takeBits(5, b);
		takeBits(3, z);
		a = a % 21;
		b = (z == 0) ? a : b % 21;
		csrWrite(lpAdrsLayerBase + 4 * idx + lpOfsHEdge, {b[15:0], a[15:0]});
		takeBits(4, a);
		takeBits(4, b);
		csrWrite(lpAdrsLayerBase + 4 * idx + lpOfsVEdge, {16'(b % 11), 16'(a % 11)});
	endtask

	// Gaps in the map and layers past the last unit
	task automatic writeUnmapped();
		logic [31:0] kind;
		logic [31:0] r;
		logic [31:0] d;
		takeBits(2, kind);
		takeBits(5, r);
		takeBits(32, d);
		case (kind)
			0: csrWrite(2, d);
			1: csrWrite(3, d);
			2: csrWrite(lpAdrsLayerBase + 4 * (r % lpLayerNum) + 3, d);
			default: csrWrite(32 + r, d);
		endcase
	endtask

	task automatic waitForHigh(ref logic sig);
		do
			@(negedge iVCLK);
		while (!sig);
	endtask

	initial
	begin
		#(lpWatchdogNs);
		$display("Watchdog expired, the raster did not finish in time");
		$display("Finished with errors");
		$fatal(1, "Timeout");
	end

	initial
	begin
		logic [31:0] r;
		iVRST    = 1'b1;
		iCsrWe   = 1'b0;
		iCsrAdrs = '0;
		iCsrWd   = '0;
		repeat (5) @(posedge iVCLK);
		iVRST <= 1'b0;
		// Outputs must stay low before enable
		repeat (10) @(posedge iVCLK);
		for (int t = 0; t < lpTestNum; t++)
		begin
			takeBits(32, r);
			csrWrite(lpAdrsBack, r);
			for (int i = 0; i < lpLayerNum; i++)
				writeLayer(i);
			writeUnmapped();
			writeUnmapped();
			takeBits(31, r);
			csrWrite(lpAdrsCtrl, {r[30:0], 1'b1});
			csrIdle();
			for (int f = 0; f < lpFrameNum; f++)
			begin
				// Vertical sync line, safe window for rewrites
				waitForHigh(oVideoVs);
				if (f < lpFrameNum - 1)
				begin
					takeBits(32, r);
					csrWrite(lpAdrsBack, r);
					for (int k = 0; k < 3; k++)
					begin
						takeBits(3, r);
						writeLayer(r % lpLayerNum);
					end
					writeUnmapped();
					csrIdle();
				end
				waitForHigh(oVideoFe);
			end
			// Stop at a random point of the next frame
			takeBits(6, r);
			repeat (r) @(posedge iVCLK);
			takeBits(31, r);
			csrWrite(lpAdrsCtrl, {r[30:0], 1'b0});
			csrIdle();
			repeat (8) @(posedge iVCLK);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
